//--- src/silverland_macros.svh
`ifndef SILVERLAND_MACROS_SVH
`define SILVERLAND_MACROS_SVH

// audio sample width.
`define SL_DAC_BITS 8

// bit positions in the firmware status word.
`define SL_ST_RESET   0
`define SL_ST_ROTATE  2
`define SL_ST_SCAN_LO 3 // two bits, 4:3.

// ps/2 set 2 make codes for the mapped keys.
`define SL_KEY_COIN   8'h2E
`define SL_KEY_START1 8'h16
`define SL_KEY_START2 8'h1E
`define SL_KEY_LEFT   8'h6B
`define SL_KEY_RIGHT  8'h74
`define SL_KEY_UP     8'h75
`define SL_KEY_DOWN   8'h72
`define SL_KEY_FIRE   8'h14 // left ctrl.

`endif

//--- src/silverland_pkg.sv
package silverland_pkg;

	// one player, bit 0 is right.
	typedef struct packed {
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	// coins and starts, as the game core expects them.
	typedef struct packed {
		logic tilt;
		logic coin4;
		logic coin3;
		logic coin2;
		logic coin1;
		logic start4;
		logic start3;
		logic start2;
		logic start1;
	} controls_t;

	// scanline darkening level.
	typedef enum logic [1:0] {
		scan_off,
		scan_25,
		scan_50,
		scan_75
	} scanline_t;

endpackage

//--- src/option_regs.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module option_regs (
	input  logic                      clock_12,
	input  logic                      rst,
	input  logic [31:0]               status,
	input  logic [1:0]                buttons,
	output logic                      rotate,
	output silverland_pkg::scanline_t scanlines,
	output logic                      game_reset
);

	logic [1:0] scan_field;

	assign scan_field = status[`SL_ST_SCAN_LO+1:`SL_ST_SCAN_LO];

	// menu reset, board button and our own reset.
	always_ff @(posedge clock_12) begin
		game_reset <= rst | status[`SL_ST_RESET] | buttons[1];
	end

	// options held in registers.
	always_ff @(posedge clock_12) begin
		if (rst) begin
			rotate    <= 1'b0;
			scanlines <= silverland_pkg::scan_off;
		end else begin
			rotate    <= status[`SL_ST_ROTATE];
			scanlines <= silverland_pkg::scanline_t'(scan_field);
		end
	end

endmodule

//--- src/arcade_inputs.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module arcade_inputs (
	input  logic                      clock_12,
	input  logic                      rst,
	input  logic                      key_strobe,
	input  logic                      key_pressed,
	input  logic [7:0]                key_code,
	input  logic [7:0]                joystick_0,
	input  logic [7:0]                joystick_1,
	input  logic                      rotate,
	output silverland_pkg::player_t   player1,
	output silverland_pkg::player_t   player2,
	output silverland_pkg::controls_t controls
);

	logic key_coin;
	logic key_start1;
	logic key_start2;
	logic key_left;
	logic key_right;
	logic key_up;
	logic key_down;
	logic key_fire;
	silverland_pkg::player_t   p1_next;
	silverland_pkg::player_t   p2_next;
	silverland_pkg::controls_t ctl_next;

	// joystick word to player bits.
	function automatic silverland_pkg::player_t from_joy(input logic [7:0] joy);
		silverland_pkg::player_t p;
		p        = '0;
		p.right  = joy[0];
		p.left   = joy[1];
		p.down   = joy[2];
		p.up     = joy[3];
		p.fire_a = joy[4];
		p.fire_b = joy[5];
		p.fire_c = joy[6];
		p.fire_d = joy[7];
		return p;
	endfunction

	// quarter turn for the upright cabinet, fire untouched.
	function automatic silverland_pkg::player_t turn(input silverland_pkg::player_t p,
	                                                 input logic rot);
		silverland_pkg::player_t q;
		q = p;
		if (rot) begin
			q.right = p.up;
			q.left  = p.down;
			q.up    = p.left;
			q.down  = p.right;
		end
		return q;
	endfunction

	always_ff @(posedge clock_12) begin
		if (rst) begin
			key_coin   <= 1'b0;
			key_start1 <= 1'b0;
			key_start2 <= 1'b0;
			key_left   <= 1'b0;
			key_right  <= 1'b0;
			key_up     <= 1'b0;
			key_down   <= 1'b0;
			key_fire   <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				`SL_KEY_COIN:   key_coin   <= key_pressed;
				`SL_KEY_START1: key_start1 <= key_pressed;
				`SL_KEY_START2: key_start2 <= key_pressed;
				`SL_KEY_LEFT:   key_left   <= key_pressed;
				`SL_KEY_RIGHT:  key_right  <= key_pressed;
				`SL_KEY_UP:     key_up     <= key_pressed;
				`SL_KEY_DOWN:   key_down   <= key_pressed;
				`SL_KEY_FIRE:   key_fire   <= key_pressed;
				default: ; // other keys ignored.
			endcase
		end
	end

	always_comb begin
		p1_next        = from_joy(joystick_0);
		p1_next.right  = p1_next.right | key_right;
		p1_next.left   = p1_next.left | key_left;
		p1_next.down   = p1_next.down | key_down;
		p1_next.up     = p1_next.up | key_up;
		p1_next.fire_a = p1_next.fire_a | key_fire;
		p1_next        = turn(p1_next, rotate);
		p2_next        = turn(from_joy(joystick_1), rotate); // joystick only.
		ctl_next        = '0;
		ctl_next.coin1  = key_coin;
		ctl_next.start1 = key_start1;
		ctl_next.start2 = key_start2;
	end

	always_ff @(posedge clock_12) begin
		if (rst) begin
			player1  <= '0;
			player2  <= '0;
			controls <= '0;
		end else begin
			player1  <= p1_next;
			player2  <= p2_next;
			controls <= ctl_next;
		end
	end

endmodule

//--- src/video_out.sv
`timescale 1ns/10ps

module video_out (
	input  logic                      clock_12,
	input  logic                      rst,
	input  logic [2:0]                game_r,
	input  logic [2:0]                game_g,
	input  logic [1:0]                game_b,
	input  logic                      game_hb,
	input  logic                      game_vb,
	input  logic                      game_hs,
	input  logic                      game_vs,
	input  silverland_pkg::scanline_t scanlines,
	output logic [5:0]                vga_r,
	output logic [5:0]                vga_g,
	output logic [5:0]                vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs
);

	logic       hs_d;
	logic       odd_line;
	logic       blank;
	logic [5:0] r_exp;
	logic [5:0] g_exp;
	logic [5:0] b_exp;

	function automatic logic [5:0] darken(input logic [5:0] v,
	                                      input silverland_pkg::scanline_t lvl);
		case (lvl)
			silverland_pkg::scan_25: darken = v - (v >> 2);
			silverland_pkg::scan_50: darken = v >> 1;
			silverland_pkg::scan_75: darken = v >> 2;
			default:                 darken = v;
		endcase
	endfunction

	assign blank = game_hb | game_vb;

	// 3/3/2 to 6 bits by bit replication.
	assign r_exp = blank ? 6'd0 : {game_r, game_r};
	assign g_exp = blank ? 6'd0 : {game_g, game_g};
	assign b_exp = blank ? 6'd0 : {game_b, game_b, game_b};

	// line parity from hsync rising edge.
	always_ff @(posedge clock_12) begin
		if (rst) begin
			hs_d     <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_d <= game_hs;
			if (game_hs & ~hs_d)
				odd_line <= ~odd_line;
		end
	end

	always_ff @(posedge clock_12) begin
		if (rst) begin
			vga_r <= 6'd0;
			vga_g <= 6'd0;
			vga_b <= 6'd0;
		end else begin
			vga_r <= odd_line ? darken(r_exp, scanlines) : r_exp;
			vga_g <= odd_line ? darken(g_exp, scanlines) : g_exp;
			vga_b <= odd_line ? darken(b_exp, scanlines) : b_exp;
		end
	end

	// syncs stay aligned with the colour stage.
	always_ff @(posedge clock_12) begin
		vga_hs <= game_hs;
		vga_vs <= game_vs;
	end

endmodule

//--- src/dac.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module dac #(
	parameter int C_bits = `SL_DAC_BITS
) (
	input  logic              clock_12,
	input  logic              rst,
	input  logic [C_bits-1:0] dac_i,
	output logic              dac_o
);

	logic [C_bits:0] acc; // top bit is the carry.

	// carry out of the sum is the pulse density.
	always_ff @(posedge clock_12) begin
		if (rst)
			acc <= '0;
		else
			acc <= {1'b0, acc[C_bits-1:0]} + {1'b0, dac_i};
	end

	assign dac_o = acc[C_bits];

endmodule

//--- src/silverland_mist.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module silverland_mist (
	input  logic                      clock_12,
	input  logic                      rst,
	input  logic [31:0]               status,
	input  logic [1:0]                buttons,
	input  logic                      key_strobe,
	input  logic                      key_pressed,
	input  logic [7:0]                key_code,
	input  logic [7:0]                joystick_0,
	input  logic [7:0]                joystick_1,
	input  logic [2:0]                game_r,
	input  logic [2:0]                game_g,
	input  logic [1:0]                game_b,
	input  logic                      game_hb,
	input  logic                      game_vb,
	input  logic                      game_hs,
	input  logic                      game_vs,
	input  logic [`SL_DAC_BITS-1:0]   audio,
	output silverland_pkg::player_t   player1,
	output silverland_pkg::player_t   player2,
	output silverland_pkg::controls_t controls,
	output logic                      game_reset,
	output logic [5:0]                vga_r,
	output logic [5:0]                vga_g,
	output logic [5:0]                vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      audio_l,
	output logic                      audio_r
);

	logic                      rotate;
	silverland_pkg::scanline_t scanlines;

	option_regs options (
		.clock_12   (clock_12),
		.rst        (rst),
		.status     (status),
		.buttons    (buttons),
		.rotate     (rotate),
		.scanlines  (scanlines),
		.game_reset (game_reset)
	);

	arcade_inputs inputs (
		.clock_12    (clock_12),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.player1     (player1),
		.player2     (player2),
		.controls    (controls)
	);

	video_out video (
		.clock_12  (clock_12),
		.rst       (rst),
		.game_r    (game_r),
		.game_g    (game_g),
		.game_b    (game_b),
		.game_hb   (game_hb),
		.game_vb   (game_vb),
		.game_hs   (game_hs),
		.game_vs   (game_vs),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	dac #(
		.C_bits (`SL_DAC_BITS)
	) dac (
		.clock_12 (clock_12),
		.rst      (rst),
		.dac_i    (audio),
		.dac_o    (audio_l)
	);

	assign audio_r = audio_l; // mono game.

endmodule

//--- test/silverland_checker.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module silverland_checker (
	input logic        clock_12,
	input logic        rst,
	input logic [31:0] status,
	input logic        game_hb,
	input logic        game_vb,
	input logic        game_hs,
	input logic        game_vs,
	input logic [5:0]  vga_r,
	input logic [5:0]  vga_g,
	input logic [5:0]  vga_b,
	input logic        vga_hs,
	input logic        vga_vs,
	input logic        game_reset
);

	reset_black: assert property (@(posedge clock_12)
		rst |=> (vga_r == 6'd0 && vga_g == 6'd0 && vga_b == 6'd0))
		else $error("colour outputs not zero while reset is held");

	// blanking shows up one stage later.
	blank_black: assert property (@(posedge clock_12)
		(game_hb || game_vb) |=> (vga_r == 6'd0 && vga_g == 6'd0 && vga_b == 6'd0))
		else $error("colour outputs not zero after a blank input");

	sync_delay: assert property (@(posedge clock_12)
		1'b1 |=> (vga_hs == $past(game_hs) && vga_vs == $past(game_vs)))
		else $error("vga syncs are not the game syncs delayed by one cycle");

	menu_reset: assert property (@(posedge clock_12)
		status[`SL_ST_RESET] |=> game_reset)
		else $error("game_reset low one cycle after status reset bit");

endmodule

bind silverland_mist silverland_checker checks (.*);

//--- test/silverland_tb.sv
`timescale 1ns/10ps
`include "silverland_macros.svh"

module silverland_tb;

	logic                      clock_12;
	logic                      rst;
	logic [31:0]               status;
	logic [1:0]                buttons;
	logic                      key_strobe;
	logic                      key_pressed;
	logic [7:0]                key_code;
	logic [7:0]                joystick_0;
	logic [7:0]                joystick_1;
	logic [2:0]                game_r;
	logic [2:0]                game_g;
	logic [1:0]                game_b;
	logic                      game_hb;
	logic                      game_vb;
	logic                      game_hs;
	logic                      game_vs;
	logic [`SL_DAC_BITS-1:0]   audio;
	silverland_pkg::player_t   player1;
	silverland_pkg::player_t   player2;
	silverland_pkg::controls_t controls;
	logic                      game_reset;
	logic [5:0]                vga_r;
	logic [5:0]                vga_g;
	logic [5:0]                vga_b;
	logic                      vga_hs;
	logic                      vga_vs;
	logic                      audio_l;
	logic                      audio_r;

	integer seed;
	int     errors;
	int     err_mark;
	int     tests;
	logic   line_odd; // model of the line parity.
	logic   hs_last;
	silverland_pkg::scanline_t level;
	silverland_pkg::player_t   exp_p1;
	silverland_pkg::controls_t exp_ctl;

	silverland_mist uut (.*);

	initial begin
		clock_12 = 1'b0;
		forever #50 clock_12 = ~clock_12;
	end

	task automatic cycles(input int n);
		repeat (n) @(posedge clock_12);
		@(negedge clock_12);
	endtask

	task automatic check_player(input string what, input silverland_pkg::player_t got,
	                            input silverland_pkg::player_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_controls(input string what, input silverland_pkg::controls_t got,
	                              input silverland_pkg::controls_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_color(input string what, input logic [5:0] er, input logic [5:0] eg,
	                           input logic [5:0] eb);
		if (vga_r !== er || vga_g !== eg || vga_b !== eb) begin
			$display("Mismatch at %0t: %s got %h/%h/%h expected %h/%h/%h", $time, what,
			         vga_r, vga_g, vga_b, er, eg, eb);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s: %0d errors", name, errors - err_mark);
	endtask

	// joystick bits from 0 up are right, left, down, up and fire a..d.
	function automatic silverland_pkg::player_t from_stick(input logic [7:0] j);
		silverland_pkg::player_t p;
		p = '0;
		{p.fire_d, p.fire_c, p.fire_b, p.fire_a} = j[7:4];
		{p.up, p.down, p.left, p.right} = j[3:0];
		return p;
	endfunction

	function automatic silverland_pkg::player_t quarter_turn(input silverland_pkg::player_t p);
		silverland_pkg::player_t q;
		q = p;
		{q.right, q.left, q.up, q.down} = {p.up, p.down, p.left, p.right};
		return q;
	endfunction

	function automatic logic [5:0] dim(input logic [5:0] v, input silverland_pkg::scanline_t l);
		if (l == silverland_pkg::scan_25)
			return v - v / 6'd4;
		else if (l == silverland_pkg::scan_50)
			return v / 6'd2;
		else if (l == silverland_pkg::scan_75)
			return v / 6'd4;
		return v;
	endfunction

	task automatic model_key(input logic [7:0] code, input logic v);
		case (code)
			`SL_KEY_COIN:   exp_ctl.coin1  = v;
			`SL_KEY_START1: exp_ctl.start1 = v;
			`SL_KEY_START2: exp_ctl.start2 = v;
			`SL_KEY_LEFT:   exp_p1.left    = v;
			`SL_KEY_RIGHT:  exp_p1.right   = v;
			`SL_KEY_UP:     exp_p1.up      = v;
			`SL_KEY_DOWN:   exp_p1.down    = v;
			`SL_KEY_FIRE:   exp_p1.fire_a  = v;
			default: ;
		endcase
	endtask

	// strobe, latch, then the registered word.
	task automatic press(input logic [7:0] code, input logic down);
		@(posedge clock_12);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= down;
		@(posedge clock_12);
		key_strobe <= 1'b0;
		cycles(1);
	endtask

	task automatic video_step(input logic [2:0] r, input logic [2:0] g, input logic [1:0] b,
	                          input logic hb, input logic vb, input logic hs, input logic vs);
		logic [5:0] er;
		logic [5:0] eg;
		logic [5:0] eb;
		@(posedge clock_12);
		game_r  <= r;
		game_g  <= g;
		game_b  <= b;
		game_hb <= hb;
		game_vb <= vb;
		game_hs <= hs;
		game_vs <= vs;
		er = (hb | vb) ? 6'd0 : {r, r};
		eg = (hb | vb) ? 6'd0 : {g, g};
		eb = (hb | vb) ? 6'd0 : {b, b, b};
		if (line_odd) begin
			er = dim(er, level);
			eg = dim(eg, level);
			eb = dim(eb, level);
		end
		if (hs & ~hs_last)
			line_odd = ~line_odd; // takes effect from the next pixel.
		hs_last = hs;
		cycles(1);
		check_color("vga colour", er, eg, eb);
		check_bit("vga_hs", vga_hs, hs);
		check_bit("vga_vs", vga_vs, vs);
	endtask

	task automatic wait_reset_release;
		int n;
		n = 0;
		while (game_reset !== 1'b0 && n < 20) begin
			cycles(1);
			n++;
		end
		if (game_reset !== 1'b0) begin
			$display("timeout: game_reset stayed high after reset was released");
			errors++;
		end
	endtask

	task automatic reset_and_options;
		check_player("player1 after reset", player1, '0);
		check_player("player2 after reset", player2, '0);
		check_controls("controls after reset", controls, '0);
		@(posedge clock_12);
		status[`SL_ST_RESET] <= 1'b1;
		cycles(1);
		check_bit("game_reset from status", game_reset, 1'b1);
		@(posedge clock_12);
		status[`SL_ST_RESET] <= 1'b0;
		cycles(1);
		check_bit("game_reset status cleared", game_reset, 1'b0);
		@(posedge clock_12);
		buttons[1] <= 1'b1;
		cycles(1);
		check_bit("game_reset from button", game_reset, 1'b1);
		@(posedge clock_12);
		buttons[1] <= 1'b0;
		cycles(1);
		check_bit("game_reset button cleared", game_reset, 1'b0);
		finish_test("reset and options");
	endtask

	task automatic keyboard;
		logic [7:0] codes [8];
		int k;
		codes = '{`SL_KEY_COIN, `SL_KEY_START1, `SL_KEY_START2, `SL_KEY_LEFT,
		          `SL_KEY_RIGHT, `SL_KEY_UP, `SL_KEY_DOWN, `SL_KEY_FIRE};
		err_mark = errors;
		for (k = 0; k < 8; k++) begin
			press(codes[k], 1'b1);
			model_key(codes[k], 1'b1);
			check_player("player1 key press", player1, exp_p1);
			check_controls("controls key press", controls, exp_ctl);
			press(codes[k], 1'b0);
			model_key(codes[k], 1'b0);
			check_player("player1 key release", player1, exp_p1);
			check_controls("controls key release", controls, exp_ctl);
		end
		press(8'h29, 1'b1); // space is not mapped.
		check_player("player1 unmapped key", player1, exp_p1);
		check_controls("controls unmapped key", controls, exp_ctl);
		press(8'h29, 1'b0);
		finish_test("keyboard");
	endtask

	task automatic joysticks_and_rotation;
		silverland_pkg::player_t e1;
		silverland_pkg::player_t e2;
		logic [31:0] rnd;
		int k;
		err_mark = errors;
		press(`SL_KEY_LEFT, 1'b1); // held through the test.
		for (k = 0; k < 16; k++) begin
			if (k == 8) begin
				@(posedge clock_12);
				status[`SL_ST_ROTATE] <= 1'b1;
				cycles(1);
			end
			rnd = $random(seed);
			@(posedge clock_12);
			joystick_0 <= rnd[7:0];
			joystick_1 <= rnd[15:8];
			e1      = from_stick(rnd[7:0]);
			e1.left = 1'b1;
			e2      = from_stick(rnd[15:8]);
			if (k >= 8) begin
				e1 = quarter_turn(e1);
				e2 = quarter_turn(e2);
			end
			cycles(1);
			check_player("player1 joystick", player1, e1);
			check_player("player2 joystick", player2, e2);
		end
		@(posedge clock_12);
		status[`SL_ST_ROTATE] <= 1'b0;
		joystick_0 <= 8'd0;
		joystick_1 <= 8'd0;
		press(`SL_KEY_LEFT, 1'b0);
		cycles(1);
		check_player("player1 idle", player1, '0);
		finish_test("joysticks and rotation");
	endtask

	task automatic video_path;
		logic [31:0] rnd;
		int k;
		err_mark = errors;
		for (k = 0; k < 24; k++) begin
			rnd = $random(seed);
			video_step(rnd[2:0], rnd[5:3], rnd[7:6], rnd[9:8] == 2'b00,
			           rnd[11:10] == 2'b00, rnd[12], rnd[13]);
		end
		finish_test("video");
	endtask

	task automatic scanline_levels;
		logic [31:0] rnd;
		int lv;
		int k;
		err_mark = errors;
		for (lv = 0; lv < 4; lv++) begin
			@(posedge clock_12);
			status[`SL_ST_SCAN_LO+1:`SL_ST_SCAN_LO] <= lv[1:0];
			level = silverland_pkg::scanline_t'(lv[1:0]);
			cycles(1);
			// hs pulses on odd steps, so both line parities are seen.
			for (k = 0; k < 6; k++) begin
				rnd = $random(seed);
				video_step(rnd[2:0], rnd[5:3], rnd[7:6], 1'b0, 1'b0, k[0], 1'b0);
			end
		end
		finish_test("scanlines");
	endtask

	task automatic audio_dac;
		logic [31:0] rnd;
		int s;
		int k;
		int n;
		int ones;
		err_mark = errors;
		for (k = 0; k < 6; k++) begin
			rnd = $random(seed);
			s = (k == 0) ? 0 : (k == 1) ? 255 : int'(rnd[7:0]);
			@(posedge clock_12);
			audio <= s[7:0];
			cycles(2);
			ones = 0;
			n    = 0;
			while (n < 256) begin // one full window.
				if (audio_l)
					ones++;
				check_bit("audio_r", audio_r, audio_l);
				n++;
				cycles(1);
			end
			if (ones > s + 1 || ones + 1 < s) begin
				$display("Mismatch at %0t: sample %0d gave %0d ones", $time, s, ones);
				errors++;
			end
		end
		finish_test("audio");
	endtask

	initial begin
		seed        = 44;
		errors      = 0;
		tests       = 0;
		err_mark    = 0;
		rst         = 1'b1;
		status      = '0;
		buttons     = '0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'd0;
		joystick_0  = 8'd0;
		joystick_1  = 8'd0;
		game_r      = 3'd5; // lit while reset is held.
		game_g      = 3'd2;
		game_b      = 2'd3;
		game_hb     = 1'b0;
		game_vb     = 1'b0;
		game_hs     = 1'b0;
		game_vs     = 1'b0;
		audio       = '0;
		line_odd    = 1'b0;
		hs_last     = 1'b0;
		level       = silverland_pkg::scan_off;
		exp_p1      = '0;
		exp_ctl     = '0;
		repeat (15) @(posedge clock_12);
		@(negedge clock_12);
		check_color("colour during reset", 6'd0, 6'd0, 6'd0);
		@(posedge clock_12);
		rst    <= 1'b0;
		game_r <= 3'd0;
		game_g <= 3'd0;
		game_b <= 2'd0;
		wait_reset_release();
		reset_and_options();
		keyboard();
		joysticks_and_rotation();
		video_path();
		scanline_levels();
		audio_dac();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- all.f
+incdir+src
src/silverland_pkg.sv
src/option_regs.sv
src/arcade_inputs.sv
src/video_out.sv
src/dac.sv
src/silverland_mist.sv
test/silverland_checker.sv
test/silverland_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= silverland_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(wildcard src/*.sv src/*.svh test/*.sv) $(FILELIST)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
